/* hdl/fir_pkg.sv */
package fir_pkg;

    ////////////////////////////////////////
    // widths and sizes
    localparam int addr_w   = 12;
    localparam int data_w   = 32;
    localparam int num_taps = 11;

    typedef logic [addr_w-1:0] addr_t;
    typedef logic [data_w-1:0] word_t;

    ////////////////////////////////////////
    // register map
    localparam addr_t reg_ap_ctrl     = 12'h000;
    localparam addr_t reg_data_length = 12'h010;
    localparam addr_t reg_tap_num     = 12'h014;
    // tap k sits at reg_tap_base + 4k
    localparam addr_t reg_tap_base    = 12'h040;

    // ap_ctrl bit positions
    localparam int ap_start_bit = 0;
    localparam int ap_done_bit  = 1;
    localparam int ap_idle_bit  = 2;

    // tap read-back value while not idle
    localparam word_t tap_read_idle_busy = 32'hFFFF_FFFF;

    ////////////////////////////////////////
    // mac engine states
    typedef enum logic [2:0] {
        mac_load,
        mac_bubble,
        mac_read,
        mac_write,
        mac_hold
    } mac_state_e;

endpackage

/* hdl/coef_if.sv */
interface coef_if;
    import fir_pkg::*;

    // host side strobes and payload
    logic  wr;
    logic  rd;
    addr_t addr;
    word_t wdata;

    // tap ram output, valid one cycle after rd
    word_t rdata;

    modport host (
        output wr,
        output rd,
        output addr,
        output wdata,
        input  rdata
    );

    modport ram (
        input  wr,
        input  rd,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

/* hdl/sample_if.sv */
interface sample_if;
    import fir_pkg::*;

    // sample towards the engine
    logic  x_valid;
    word_t x_data;
    logic  x_last;
    logic  x_take;

    // result back to the stream side
    logic  y_valid;
    word_t y_data;
    logic  y_taken;

    modport buffer (
        output x_valid, x_data, x_last, y_taken,
        input  x_take, y_valid, y_data
    );

    modport calc (
        input  x_valid, x_data, y_taken,
        output x_take, y_valid, y_data
    );

endinterface

/* hdl/fir_ctrl_regs.sv */
module fir_ctrl_regs (
    input  logic           axis_clk,
    input  logic           axis_rst_n,
    input  logic           awvalid,
    input  fir_pkg::addr_t awaddr,
    output logic           awready,
    input  logic           wvalid,
    input  fir_pkg::word_t wdata,
    output logic           wready,
    input  logic           arvalid,
    input  fir_pkg::addr_t araddr,
    output logic           arready,
    output logic           rvalid,
    input  logic           rready,
    output fir_pkg::word_t rdata,
    input  logic           last_done,
    output logic           start,
    output logic           running,
    coef_if.host           coef
);
    import fir_pkg::*;

    addr_t wr_addr;
    word_t wr_data;
    addr_t rd_addr;
    logic  aw_held;
    logic  w_held;
    logic  aw_take;
    logic  w_take;
    logic  ar_take;
    logic  wr_fire;
    logic  wr_start;
    logic  rd_stage;
    logic  rd_tap_ok;
    logic  tap_wr;
    logic  tap_rd;
    logic  ap_done;
    logic  ap_idle;
    word_t ap_ctrl;
    word_t data_length;
    word_t tap_num;

    function automatic logic is_tap(input addr_t a);
        return (a >= reg_tap_base) && (a < addr_t'(reg_tap_base + 4 * num_taps));
    endfunction

    function automatic addr_t tap_index(input addr_t a);
        return (a - reg_tap_base) >> 2;
    endfunction

    ////////////////////////////////////////
    // write channel, address and data held independently
    assign aw_take = awvalid && !aw_held && !awready;
    assign w_take  = wvalid && !w_held && !wready;
    // a write yields one cycle to a read that owns the tap port
    assign wr_fire = aw_held && w_held && !arready;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
        end else begin
            awready <= aw_take;
            wready  <= w_take;
            if (aw_take) begin
                aw_held <= 1'b1;
            end else if (wr_fire) begin
                aw_held <= 1'b0;
            end
            if (w_take) begin
                w_held <= 1'b1;
            end else if (wr_fire) begin
                w_held <= 1'b0;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (aw_take) begin
            wr_addr <= awaddr;
        end
        if (w_take) begin
            wr_data <= wdata;
        end
        if (ar_take) begin
            rd_addr <= araddr;
        end
    end

    ////////////////////////////////////////
    // read channel
    // arready, then tap ram access, then rvalid
    assign ar_take = arvalid && !arready && !rd_stage && !rvalid;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            arready   <= 1'b0;
            rd_stage  <= 1'b0;
            rd_tap_ok <= 1'b0;
            rvalid    <= 1'b0;
        end else begin
            arready   <= ar_take;
            rd_stage  <= arready;
            rd_tap_ok <= tap_rd;
            if (rd_stage) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (rd_stage) begin
            if (rd_addr == reg_ap_ctrl) begin
                rdata <= ap_ctrl;
            end else if (rd_addr == reg_data_length) begin
                rdata <= data_length;
            end else if (rd_addr == reg_tap_num) begin
                rdata <= tap_num;
            end else if (rd_tap_ok) begin
                rdata <= coef.rdata;
            end else if (is_tap(rd_addr)) begin
                rdata <= tap_read_idle_busy;
            end else begin
                rdata <= '0;
            end
        end
    end

    // coefficient port, only touched while idle
    assign tap_wr     = wr_fire && ap_idle && is_tap(wr_addr);
    assign tap_rd     = arready && ap_idle && is_tap(rd_addr);
    assign coef.wr    = tap_wr;
    assign coef.rd    = tap_rd;
    assign coef.addr  = tap_wr ? tap_index(wr_addr) : tap_index(rd_addr);
    assign coef.wdata = wr_data;

    ////////////////////////////////////////
    // ap_ctrl sequencing
    assign wr_start = wr_fire && ap_idle && (wr_addr == reg_ap_ctrl) && wr_data[ap_start_bit];

    always_comb begin
        ap_ctrl               = '0;
        ap_ctrl[ap_start_bit] = start;
        ap_ctrl[ap_done_bit]  = ap_done;
        ap_ctrl[ap_idle_bit]  = ap_idle;
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            start   <= 1'b0;
            running <= 1'b0;
            ap_done <= 1'b0;
            ap_idle <= 1'b1;
        end else begin
            // engine takes start on its single high cycle
            if (start) begin
                start   <= 1'b0;
                ap_idle <= 1'b0;
                running <= 1'b1;
            end else if (wr_start) begin
                start <= 1'b1;
            end
            if (last_done) begin
                ap_done <= 1'b1;
                running <= 1'b0;
            end else if (rd_stage && (rd_addr == reg_ap_ctrl) && ap_done) begin
                // read to clear
                ap_done <= 1'b0;
                ap_idle <= 1'b1;
            end
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            data_length <= '0;
            tap_num     <= '0;
        end else if (wr_fire && ap_idle) begin
            if (wr_addr == reg_data_length) begin
                data_length <= wr_data;
            end
            if (wr_addr == reg_tap_num) begin
                tap_num <= wr_data;
            end
        end
    end

endmodule

/* hdl/fir_stream_io.sv */
module fir_stream_io (
    input  logic           axis_clk,
    input  logic           axis_rst_n,
    input  logic           ss_tvalid,
    input  fir_pkg::word_t ss_tdata,
    input  logic           ss_tlast,
    output logic           ss_tready,
    input  logic           sm_tready,
    output logic           sm_tvalid,
    output fir_pkg::word_t sm_tdata,
    output logic           sm_tlast,
    input  logic           running,
    output logic           last_done,
    sample_if.buffer       smp
);

    logic busy;
    logic capture;

    // one sample in flight until its result is accepted
    assign capture = ss_tvalid && running && !busy;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            busy        <= 1'b0;
            ss_tready   <= 1'b0;
            smp.x_valid <= 1'b0;
            sm_tvalid   <= 1'b0;
        end else begin
            ss_tready <= capture;
            if (capture) begin
                busy <= 1'b1;
            end else if (smp.y_taken) begin
                busy <= 1'b0;
            end
            if (capture) begin
                smp.x_valid <= 1'b1;
            end else if (smp.x_take) begin
                smp.x_valid <= 1'b0;
            end
            // result held until the sink takes it
            if (smp.y_valid) begin
                sm_tvalid <= 1'b1;
            end else if (smp.y_taken) begin
                sm_tvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (capture) begin
            smp.x_data <= ss_tdata;
            smp.x_last <= ss_tlast;
        end
        if (smp.y_valid) begin
            sm_tdata <= smp.y_data;
        end
    end

    // tlast of the sample in flight rides along with its result
    assign smp.y_taken = sm_tvalid && sm_tready;
    assign sm_tlast    = sm_tvalid && smp.x_last;
    assign last_done   = smp.y_taken && smp.x_last;

endmodule

/* hdl/fir_mac_engine.sv */
module fir_mac_engine (
    input  logic           axis_clk,
    input  logic           axis_rst_n,
    input  logic           start,
    input  logic           running,
    output logic [3:0]     tap_we,
    output logic           tap_en,
    output fir_pkg::word_t tap_di,
    output fir_pkg::addr_t tap_wa,
    output fir_pkg::addr_t tap_ra,
    input  fir_pkg::word_t tap_do,
    output logic [3:0]     data_we,
    output logic           data_en,
    output fir_pkg::word_t data_di,
    output fir_pkg::addr_t data_wa,
    output fir_pkg::addr_t data_ra,
    input  fir_pkg::word_t data_do,
    coef_if.ram            coef,
    sample_if.calc         smp
);
    import fir_pkg::*;

    mac_state_e state;
    addr_t      k;
    addr_t      hist;
    addr_t      rd_k;
    logic       rd_issue;
    logic       y_valid_r;
    word_t      x_cur;
    word_t      d_sel;
    word_t      d_keep;
    word_t      prod;
    word_t      acc;

    function automatic addr_t byte_addr(input addr_t idx);
        return idx << 2;
    endfunction

    ////////////////////////////////////////
    // read issue, taps walked from last down to 0
    always_comb begin
        rd_issue = 1'b0;
        rd_k     = k - 1'b1;
        case (state)
            mac_load: begin
                rd_issue = smp.x_valid;
                rd_k     = addr_t'(num_taps - 1);
            end
            mac_write: begin
                rd_issue = (k != '0);
            end
            default: begin
                rd_issue = 1'b0;
            end
        endcase
    end

    // x[n-k] for tap k, zero where no sample was stored this run
    always_comb begin
        if (k == '0) begin
            d_sel = x_cur;
        end else if (k <= hist) begin
            d_sel = data_do;
        end else begin
            d_sel = '0;
        end
    end

    // data ram slot j holds x[n-j]; slot k-1 read, slot k written
    assign data_en = (rd_issue && (rd_k != '0)) || (state == mac_write);
    assign data_we = {4{state == mac_write}};
    assign data_wa = byte_addr(k);
    assign data_ra = byte_addr(rd_k - 1'b1);
    assign data_di = d_keep;

    // tap ram belongs to the host port while not running
    assign tap_en     = running ? rd_issue : (coef.wr || coef.rd);
    assign tap_we     = {4{!running && coef.wr}};
    assign tap_wa     = byte_addr(coef.addr);
    assign tap_ra     = running ? byte_addr(rd_k) : byte_addr(coef.addr);
    assign tap_di     = coef.wdata;
    assign coef.rdata = tap_do;

    assign smp.x_take  = (state == mac_load) && smp.x_valid;
    assign smp.y_valid = y_valid_r;
    assign smp.y_data  = acc;

    ////////////////////////////////////////
    // state machine
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state     <= mac_load;
            k         <= '0;
            hist      <= '0;
            y_valid_r <= 1'b0;
        end else begin
            y_valid_r <= 1'b0;
            // new run, earlier samples count as zero
            if (start) begin
                hist <= '0;
            end
            case (state)
                mac_load: begin
                    if (smp.x_valid) begin
                        k     <= addr_t'(num_taps - 1);
                        state <= mac_bubble;
                    end
                end
                mac_bubble: begin
                    state <= mac_read;
                end
                mac_read: begin
                    state <= mac_write;
                end
                mac_write: begin
                    if (k == '0) begin
                        y_valid_r <= 1'b1;
                        state     <= mac_hold;
                        if (hist < addr_t'(num_taps - 1)) begin
                            hist <= hist + 1'b1;
                        end
                    end else begin
                        k     <= k - 1'b1;
                        state <= mac_read;
                    end
                end
                mac_hold: begin
                    if (smp.y_taken) begin
                        state <= mac_load;
                    end
                end
                default: begin
                    state <= mac_load;
                end
            endcase
        end
    end

    // multiply in mac_read, accumulate in mac_write
    always_ff @(posedge axis_clk) begin
        case (state)
            mac_load: begin
                if (smp.x_valid) begin
                    x_cur <= smp.x_data;
                    acc   <= '0;
                end
            end
            mac_read: begin
                prod   <= tap_do * d_sel;
                d_keep <= d_sel;
            end
            mac_write: begin
                acc <= acc + prod;
            end
            default: begin
            end
        endcase
    end

endmodule

/* hdl/fir.sv */
module fir (
    output logic           awready,
    output logic           wready,
    input  logic           awvalid,
    input  fir_pkg::addr_t awaddr,
    input  logic           wvalid,
    input  fir_pkg::word_t wdata,
    output logic           arready,
    input  logic           rready,
    input  logic           arvalid,
    input  fir_pkg::addr_t araddr,
    output logic           rvalid,
    output fir_pkg::word_t rdata,
    input  logic           ss_tvalid,
    input  fir_pkg::word_t ss_tdata,
    input  logic           ss_tlast,
    output logic           ss_tready,
    input  logic           sm_tready,
    output logic           sm_tvalid,
    output fir_pkg::word_t sm_tdata,
    output logic           sm_tlast,

    // tap ram
    output logic [3:0]     tap_we,
    output logic           tap_en,
    output fir_pkg::word_t tap_di,
    output fir_pkg::addr_t tap_wa,
    output fir_pkg::addr_t tap_ra,
    input  fir_pkg::word_t tap_do,

    // data ram
    output logic [3:0]     data_we,
    output logic           data_en,
    output fir_pkg::word_t data_di,
    output fir_pkg::addr_t data_wa,
    output fir_pkg::addr_t data_ra,
    input  fir_pkg::word_t data_do,

    input  logic           axis_clk,
    input  logic           axis_rst_n
);

    logic start;
    logic running;
    logic last_done;

    coef_if   coef ();
    sample_if smp ();

    fir_ctrl_regs u_ctrl_regs (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .awready    (awready),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .wready     (wready),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arready    (arready),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .last_done  (last_done),
        .start      (start),
        .running    (running),
        .coef       (coef.host)
    );

    fir_stream_io u_stream_io (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .ss_tvalid  (ss_tvalid),
        .ss_tdata   (ss_tdata),
        .ss_tlast   (ss_tlast),
        .ss_tready  (ss_tready),
        .sm_tready  (sm_tready),
        .sm_tvalid  (sm_tvalid),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast),
        .running    (running),
        .last_done  (last_done),
        .smp        (smp.buffer)
    );

    fir_mac_engine u_mac_engine (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .start      (start),
        .running    (running),
        .tap_we     (tap_we),
        .tap_en     (tap_en),
        .tap_di     (tap_di),
        .tap_wa     (tap_wa),
        .tap_ra     (tap_ra),
        .tap_do     (tap_do),
        .data_we    (data_we),
        .data_en    (data_en),
        .data_di    (data_di),
        .data_wa    (data_wa),
        .data_ra    (data_ra),
        .data_do    (data_do),
        .coef       (coef.ram),
        .smp        (smp.calc)
    );

endmodule

/* tests/bram_model.sv */
module bram_model (
    input  logic           clk,
    input  logic [3:0]     we,
    input  logic           en,
    input  fir_pkg::word_t wdata,
    input  fir_pkg::addr_t waddr,
    input  fir_pkg::addr_t raddr,
    output fir_pkg::word_t rdata
);
    timeunit 1ns;
    timeprecision 1ps;
    import fir_pkg::*;

    word_t mem [0:1023];

    // fill pattern from the word index, so stale words are never zero
    initial begin
        for (int i = 0; i < 1024; i++) begin
            mem[i] = 32'hC3A5_0000 ^ (i * 32'h0001_0001);
        end
        rdata = '0;
    end

    // byte write enables, read returns the old word
    always @(posedge clk) begin
        if (en) begin
            for (int b = 0; b < 4; b++) begin
                if (we[b]) begin
                    mem[waddr[11:2]][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
            rdata <= mem[raddr[11:2]];
        end
    end

endmodule

/* tests/fir_tb.sv */
module fir_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import fir_pkg::*;

    ////////////////////////////////////////
    // run length and limits
    localparam int hs_limit      = 400;
    localparam int total_samples = 11 + 24 + 16;
    localparam int pass_cycles   = 2 + 2 * num_taps;
    localparam int reg_accesses  = 80;
    localparam int watchdog_ns   =
        2 * 10 * (16 + total_samples * (pass_cycles + 12) + reg_accesses * 12);

    logic       axis_clk;
    logic       axis_rst_n;
    logic       awready;
    logic       wready;
    logic       awvalid;
    addr_t      awaddr;
    logic       wvalid;
    word_t      wdata;
    logic       arready;
    logic       rready;
    logic       arvalid;
    addr_t      araddr;
    logic       rvalid;
    word_t      rdata;
    logic       ss_tvalid;
    word_t      ss_tdata;
    logic       ss_tlast;
    logic       ss_tready;
    logic       sm_tready;
    logic       sm_tvalid;
    word_t      sm_tdata;
    logic       sm_tlast;
    logic [3:0] tap_we;
    logic       tap_en;
    word_t      tap_di;
    addr_t      tap_wa;
    addr_t      tap_ra;
    word_t      tap_do;
    logic [3:0] data_we;
    logic       data_en;
    word_t      data_di;
    addr_t      data_wa;
    addr_t      data_ra;
    word_t      data_do;

    int    errors;
    int    checks;
    int    tests_run;
    word_t lcg_state;
    word_t coefs [0:num_taps-1];
    word_t samples [0:63];
    word_t expected [0:63];

    fir DUT (.*);

    bram_model tap_ram (
        .clk   (axis_clk),
        .we    (tap_we),
        .en    (tap_en),
        .wdata (tap_di),
        .waddr (tap_wa),
        .raddr (tap_ra),
        .rdata (tap_do)
    );

    bram_model data_ram (
        .clk   (axis_clk),
        .we    (data_we),
        .en    (data_en),
        .wdata (data_di),
        .waddr (data_wa),
        .raddr (data_ra),
        .rdata (data_do)
    );

    initial begin
        axis_clk = 1'b0;
        forever #5 axis_clk = ~axis_clk;
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog: the run did not finish within %0d ns", watchdog_ns);
        $display("CHECKS FAILED");
        $finish;
    end

    ////////////////////////////////////////
    // helpers
    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic addr_t tap_addr(input int k);
        return reg_tap_base + addr_t'(4 * k);
    endfunction

    // y[n] over the current sample array, zero before the first sample
    function automatic word_t convolve(input int n);
        word_t acc;
        acc = '0;
        for (int k = 0; k < num_taps; k++) begin
            if (n - k >= 0) begin
                acc = acc + coefs[k] * samples[n - k];
            end
        end
        return acc;
    endfunction

    task automatic check_value(input string name, input word_t exp_val, input word_t act_val);
        checks++;
        if (exp_val !== act_val) begin
            errors++;
            $display("mismatch at %0d ns: %s expected %h, got %h", $time, name, exp_val, act_val);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        $display("test %s finished, %0d errors", name, errors - errors_before);
    endtask

    task automatic reg_write(input addr_t addr, input word_t data);
        bit aw_done;
        bit w_done;
        int cycles;
        aw_done = 1'b0;
        w_done  = 1'b0;
        cycles  = 0;
        @(negedge axis_clk);
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        do begin
            @(negedge axis_clk);
            cycles++;
            if (awready) begin
                aw_done = 1'b1;
                awvalid = 1'b0;
            end
            if (wready) begin
                w_done = 1'b1;
                wvalid = 1'b0;
            end
        end while (!(aw_done && w_done) && cycles < hs_limit);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        if (!(aw_done && w_done)) begin
            errors++;
            $display("register write to %h was never acknowledged", addr);
        end
    endtask

    task automatic reg_read(input addr_t addr, output word_t data);
        int cycles;
        cycles = 0;
        data   = '0;
        @(negedge axis_clk);
        arvalid = 1'b1;
        araddr  = addr;
        do begin
            @(negedge axis_clk);
            cycles++;
        end while (!arready && cycles < hs_limit);
        arvalid = 1'b0;
        if (!arready) begin
            errors++;
            $display("register read of %h got no arready", addr);
            return;
        end
        cycles = 0;
        do begin
            @(negedge axis_clk);
            cycles++;
        end while (!rvalid && cycles < hs_limit);
        if (!rvalid) begin
            errors++;
            $display("register read of %h never returned data", addr);
            return;
        end
        data   = rdata;
        rready = 1'b1;
        @(negedge axis_clk);
        rready = 1'b0;
    endtask

    task automatic send_samples(input int n);
        int cycles;
        for (int i = 0; i < n; i++) begin
            ss_tvalid = 1'b1;
            ss_tdata  = samples[i];
            ss_tlast  = (i == n - 1);
            cycles    = 0;
            do begin
                @(negedge axis_clk);
                cycles++;
            end while (!ss_tready && cycles < hs_limit);
            if (!ss_tready) begin
                ss_tvalid = 1'b0;
                ss_tlast  = 1'b0;
                errors++;
                $display("sample %0d was never accepted on ss_tready", i);
                return;
            end
        end
        ss_tvalid = 1'b0;
        ss_tlast  = 1'b0;
    endtask

    task automatic collect_results(input int n, input bit stall);
        int cycles;
        int delay;
        for (int i = 0; i < n; i++) begin
            cycles = 0;
            while (!sm_tvalid && cycles < hs_limit) begin
                @(negedge axis_clk);
                cycles++;
            end
            if (!sm_tvalid) begin
                errors++;
                $display("no result appeared on sm_tvalid for sample %0d", i);
                return;
            end
            delay = stall ? int'(lcg_next() % 32'd4) : 0;
            // back-pressure, no new sample may be taken meanwhile
            repeat (delay) begin
                @(negedge axis_clk);
                check_value("ss_tready", '0, word_t'(ss_tready));
                check_value("sm_tvalid", 32'd1, word_t'(sm_tvalid));
            end
            check_value("sm_tdata", expected[i], sm_tdata);
            check_value("sm_tlast", word_t'(i == n - 1), word_t'(sm_tlast));
            sm_tready = 1'b1;
            @(negedge axis_clk);
            sm_tready = 1'b0;
        end
    endtask

    task automatic stream_run(input int n, input bit stall);
        @(negedge axis_clk);
        fork
            send_samples(n);
            collect_results(n, stall);
        join
    endtask

    // done shows first, the read clears it and idle comes back
    task automatic clear_done();
        word_t v;
        reg_read(reg_ap_ctrl, v);
        check_value("ap_ctrl after run", 32'h2, v);
        reg_read(reg_ap_ctrl, v);
        check_value("ap_ctrl after clear", 32'h4, v);
    endtask

    ////////////////////////////////////////
    // directed tests
    task automatic check_after_reset();
        int    e0;
        word_t v;
        e0 = errors;
        check_value("sm_tvalid", '0, word_t'(sm_tvalid));
        check_value("sm_tlast", '0, word_t'(sm_tlast));
        check_value("ss_tready", '0, word_t'(ss_tready));
        check_value("awready", '0, word_t'(awready));
        check_value("wready", '0, word_t'(wready));
        check_value("arready", '0, word_t'(arready));
        check_value("rvalid", '0, word_t'(rvalid));
        check_value("tap_en", '0, word_t'(tap_en));
        check_value("data_en", '0, word_t'(data_en));
        check_value("tap_we", '0, word_t'(tap_we));
        check_value("data_we", '0, word_t'(data_we));
        reg_read(reg_ap_ctrl, v);
        check_value("ap_ctrl", 32'h4, v);
        report_test("reset state", e0);
    endtask

    task automatic idle_register_access();
        int    e0;
        word_t v;
        e0 = errors;
        reg_write(reg_data_length, 32'd24);
        reg_write(reg_tap_num, word_t'(num_taps));
        for (int k = 0; k < num_taps; k++) begin
            coefs[k] = lcg_next();
            reg_write(tap_addr(k), coefs[k]);
        end
        reg_read(reg_data_length, v);
        check_value("data_length", 32'd24, v);
        reg_read(reg_tap_num, v);
        check_value("tap_num", word_t'(num_taps), v);
        for (int k = 0; k < num_taps; k++) begin
            reg_read(tap_addr(k), v);
            check_value($sformatf("tap %0d", k), coefs[k], v);
        end
        report_test("idle register access", e0);
    endtask

    task automatic busy_register_access();
        int    e0;
        word_t v;
        e0 = errors;
        reg_write(reg_ap_ctrl, 32'h1);
        reg_read(reg_ap_ctrl, v);
        check_value("ap_ctrl idle bit", '0, word_t'(v[ap_idle_bit]));
        check_value("ap_ctrl done bit", '0, word_t'(v[ap_done_bit]));
        reg_read(tap_addr(3), v);
        check_value("tap 3 while running", tap_read_idle_busy, v);
        // must be ignored, checked once the run is over
        reg_write(tap_addr(3), 32'hDEAD_BEEF);
        report_test("busy register access", e0);
    endtask

    task automatic impulse_response();
        int e0;
        e0 = errors;
        for (int i = 0; i < num_taps; i++) begin
            samples[i]  = (i == 0) ? 32'd1 : 32'd0;
            expected[i] = coefs[i];
        end
        stream_run(num_taps, 1'b0);
        clear_done();
        report_test("impulse response", e0);
    endtask

    task automatic taps_after_run();
        int    e0;
        word_t v;
        e0 = errors;
        for (int k = 0; k < num_taps; k++) begin
            reg_read(tap_addr(k), v);
            check_value($sformatf("tap %0d after run", k), coefs[k], v);
        end
        report_test("taps after run", e0);
    endtask

    task automatic random_stream();
        int e0;
        e0 = errors;
        for (int i = 0; i < 24; i++) begin
            samples[i] = lcg_next();
        end
        for (int i = 0; i < 24; i++) begin
            expected[i] = convolve(i);
        end
        reg_write(reg_ap_ctrl, 32'h1);
        stream_run(24, 1'b1);
        clear_done();
        report_test("random stream", e0);
    endtask

    // history of the previous run must not leak in
    task automatic second_run();
        int e0;
        e0 = errors;
        for (int i = 0; i < 16; i++) begin
            samples[i] = lcg_next();
        end
        for (int i = 0; i < 16; i++) begin
            expected[i] = convolve(i);
        end
        reg_write(reg_ap_ctrl, 32'h1);
        stream_run(16, 1'b1);
        clear_done();
        report_test("second run", e0);
    endtask

    ////////////////////////////////////////
    // main sequence
    initial begin
        errors     = 0;
        checks     = 0;
        tests_run  = 0;
        lcg_state  = 32'd14;
        axis_rst_n = 1'b0;
        awvalid    = 1'b0;
        awaddr     = '0;
        wvalid     = 1'b0;
        wdata      = '0;
        arvalid    = 1'b0;
        araddr     = '0;
        rready     = 1'b0;
        ss_tvalid  = 1'b0;
        ss_tdata   = '0;
        ss_tlast   = 1'b0;
        sm_tready  = 1'b0;
        repeat (16) @(posedge axis_clk);
        @(negedge axis_clk);
        axis_rst_n = 1'b1;

        check_after_reset();
        idle_register_access();
        busy_register_access();
        impulse_response();
        taps_after_run();
        random_stream();
        second_run();

        $display("tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
hdl/fir_pkg.sv
hdl/coef_if.sv
hdl/sample_if.sv
hdl/fir_ctrl_regs.sv
hdl/fir_stream_io.sv
hdl/fir_mac_engine.sv
hdl/fir.sv
tests/bram_model.sv
tests/fir_tb.sv

/* Makefile */
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module fir_tb -f project.f

sim:
	verilator --binary --timing --top-module fir_tb -Mdir obj_dir -o fir_sim -f project.f
	./obj_dir/fir_sim | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
